// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = dummy_instr_tb
FILELIST  = compile.f
BUILD     = obj_dir
EXE       = dummy_instr_sim
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(EXE)
	-./$(BUILD)/$(EXE) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== compile.f ====
hw/dummy_pkg.sv
hw/dummy_csr.sv
hw/dummy_lfsr.sv
hw/dummy_insert_ctrl.sv
hw/dummy_instr_top.sv
verif/dummy_instr_checker.sv
verif/dummy_instr_tb.sv

// ==== hw/dummy_csr.sv ====
////////////////////////////////////////
// Software-visible control and seed registers of the insertion unit.
// Writes land on the next edge; the next values and write strobes are
// exported so that a checker can follow software updates.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_csr import dummy_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          csr_we,
  input  csr_sel_e      csr_sel,
  input  logic [31:0]   csr_wdata,
  output logic [31:0]   csr_rdata,
  output xsecure_ctrl_t xsecure_ctrl,
  output logic          seed_load,
  output logic          cpuctrl_we,
  output cpuctrl_t      cpuctrl_n,
  output logic          secureseed0_we,
  output logic [31:0]   secureseed0_n
);

  // Register storage
  cpuctrl_t    cpuctrl_q;
  logic [31:0] secureseed0_q;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  // Only the low five bits of the data word are implemented in cpuctrl
  assign cpuctrl_n     = cpuctrl_t'(csr_wdata[4:0]);
  assign secureseed0_n = csr_wdata;

  assign cpuctrl_we     = csr_we && (csr_sel == CSR_CPUCTRL);
  assign secureseed0_we = csr_we && (csr_sel == CSR_SECURESEED0);

  // The LFSR picks up the new seed on the same edge as the register
  assign seed_load = secureseed0_we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpuctrl_q     <= '0;
      secureseed0_q <= '0;
    end else begin
      if (cpuctrl_we) begin
        cpuctrl_q <= cpuctrl_n;
      end
      if (secureseed0_we) begin
        secureseed0_q <= secureseed0_n;
      end
    end
  end

  ////////////////////////////////////////
  // Readback and outputs
  ////////////////////////////////////////

  // Unimplemented cpuctrl bits read as zero
  always_comb begin
    case (csr_sel)
      CSR_CPUCTRL:     csr_rdata = {27'd0, cpuctrl_q};
      CSR_SECURESEED0: csr_rdata = secureseed0_q;
      default:         csr_rdata = '0;
    endcase
  end

  assign xsecure_ctrl.cpuctrl = cpuctrl_q;
  assign xsecure_ctrl.lfsr0   = secureseed0_q;

endmodule

// ==== hw/dummy_insert_ctrl.sv ====
////////////////////////////////////////
// Counts issued instructions and raises a one-cycle insert pulse once
// the count passes the random compare value from the LFSR.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_insert_ctrl import dummy_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  xsecure_ctrl_t            xsecure_ctrl,
  input  logic                     instr_issue,
  input  logic [LFSRCNT_WIDTH-1:0] lfsr_cnt,
  output logic                     dummy_insert
);

  // Issued instructions since the last insert or since enable
  logic [CNT_WIDTH-1:0] cnt_q;

  // Compare value widened to the counter width
  logic [CNT_WIDTH-1:0] cmp_val;

  logic enable;
  logic cnt_passed;
  logic cnt_inc;

  assign enable  = xsecure_ctrl.cpuctrl.rnddummy;
  assign cmp_val = CNT_WIDTH'(lfsr_cnt);

  ////////////////////////////////////////
  // Insert decision
  ////////////////////////////////////////

  // The counter reaches lfsr_cnt+1 on the edge of the last issue, so the
  // pulse shows one cycle after that edge
  assign cnt_passed   = cnt_q > cmp_val;
  assign dummy_insert = enable && cnt_passed;

  // Counting stops once the compare value is passed, which keeps the
  // counter from running past lfsr_cnt+1
  assign cnt_inc = instr_issue && !cnt_passed;

  ////////////////////////////////////////
  // Counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!enable) begin
      // Held at zero while disabled so that enable restarts from zero
      cnt_q <= '0;
    end else if (dummy_insert) begin
      // Issues during the pulse are not counted
      cnt_q <= '0;
    end else if (cnt_inc) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// ==== hw/dummy_instr_top.sv ====
////////////////////////////////////////
// Dummy-instruction insertion unit, top level.
// Joins the register block, the LFSR and the insert controller; the
// insert pulse also steps the LFSR.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_instr_top import dummy_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        csr_we,
  input  csr_sel_e    csr_sel,
  input  logic [31:0] csr_wdata,
  output logic [31:0] csr_rdata,
  input  logic        instr_issue,
  output logic        dummy_insert
);

  // Register outputs to the datapath
  xsecure_ctrl_t xsecure_ctrl;
  logic          seed_load;

  // Next values and strobes, watched by the checker
  logic          cpuctrl_we;
  cpuctrl_t      cpuctrl_n;
  logic          secureseed0_we;
  logic [31:0]   secureseed0_n;

  // Random compare value
  logic [LFSRCNT_WIDTH-1:0] lfsr_cnt;

  dummy_csr dummy_csr_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_we         (csr_we),
    .csr_sel        (csr_sel),
    .csr_wdata      (csr_wdata),
    .csr_rdata      (csr_rdata),
    .xsecure_ctrl   (xsecure_ctrl),
    .seed_load      (seed_load),
    .cpuctrl_we     (cpuctrl_we),
    .cpuctrl_n      (cpuctrl_n),
    .secureseed0_we (secureseed0_we),
    .secureseed0_n  (secureseed0_n)
  );

  // Each inserted dummy moves the generator to its next value
  dummy_lfsr dummy_lfsr_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .seed_load     (seed_load),
    .xsecure_ctrl  (xsecure_ctrl),
    .secureseed0_n (secureseed0_n),
    .step          (dummy_insert),
    .lfsr_cnt      (lfsr_cnt)
  );

  dummy_insert_ctrl dummy_insert_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .xsecure_ctrl (xsecure_ctrl),
    .instr_issue  (instr_issue),
    .lfsr_cnt     (lfsr_cnt),
    .dummy_insert (dummy_insert)
  );

endmodule

// ==== hw/dummy_lfsr.sv ====
////////////////////////////////////////
// Seedable 32-bit Galois LFSR that steps once per inserted dummy.
// Its low bits, masked by the frequency field, give the compare value.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_lfsr import dummy_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     seed_load,
  input  xsecure_ctrl_t            xsecure_ctrl,
  input  logic [31:0]              secureseed0_n,
  input  logic                     step,
  output logic [LFSRCNT_WIDTH-1:0] lfsr_cnt
);

  logic [LFSR_WIDTH-1:0]  lfsr_q;
  logic [LFSR_WIDTH-1:0]  lfsr_step;
  logic [LFSR_WIDTH-1:0]  seed_val;
  logic [3:0]             freq_c;
  logic [LFSRCNT_WIDTH:0] mask_full;

  ////////////////////////////////////////
  // State update
  ////////////////////////////////////////

  // Shift right, then fold in the taps when a one falls out of bit 0
  assign lfsr_step = {1'b0, lfsr_q[LFSR_WIDTH-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

  // An all-zero state would lock the register, so zero means default
  assign seed_val = (secureseed0_n == '0) ? LFSR_DEFAULT_SEED : secureseed0_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_DEFAULT_SEED;
    end else if (seed_load) begin
      // A seed write wins over a step in the same cycle
      lfsr_q <= seed_val;
    end else if (step && xsecure_ctrl.cpuctrl.rnddummy) begin
      lfsr_q <= lfsr_step;
    end
  end

  ////////////////////////////////////////
  // Compare value
  ////////////////////////////////////////

  // Codes above the maximum act like the maximum
  assign freq_c = (xsecure_ctrl.cpuctrl.rnddummyfreq > FREQ_MAX) ?
                  FREQ_MAX : xsecure_ctrl.cpuctrl.rnddummyfreq;

  // Mask of freq+2 ones, so 3 at code 0 up to 63 at code 4
  assign mask_full = ({{LFSRCNT_WIDTH{1'b0}}, 1'b1} << (freq_c + 4'd2)) - 1'b1;

  assign lfsr_cnt = lfsr_q[LFSRCNT_WIDTH-1:0] & mask_full[LFSRCNT_WIDTH-1:0];

endmodule

// ==== hw/dummy_pkg.sv ====
////////////////////////////////////////
// Shared types and constants for the dummy-instruction insertion unit.
// Imported by the register block, the LFSR, the insert controller and
// the bound checker.
////////////////////////////////////////

package dummy_pkg;

  ////////////////////////////////////////
  // Sizes and constants
  ////////////////////////////////////////

  // State width of the random number generator
  localparam int unsigned LFSR_WIDTH = 32;

  // Galois feedback taps for a maximal-length 32-bit sequence
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 32'h8000_0057;

  // Loaded at reset, and whenever software writes an all-zero seed
  localparam logic [LFSR_WIDTH-1:0] LFSR_DEFAULT_SEED = 32'hC0DE_5EED;

  // Instruction counter, one bit wider than the compare value so that
  // the count can pass the largest compare value without wrapping
  localparam int unsigned CNT_WIDTH = 7;

  // Width of the masked compare value taken from the LFSR state
  localparam int unsigned LFSRCNT_WIDTH = 6;

  // Largest frequency code honoured; anything above is clamped to this
  localparam logic [3:0] FREQ_MAX = 4'd4;

  ////////////////////////////////////////
  // Register types
  ////////////////////////////////////////

  // Control register, kept in bits 4:0 of the 32-bit word
  typedef struct packed {
    logic [3:0] rnddummyfreq;
    logic       rnddummy;
  } cpuctrl_t;

  // Everything the datapath needs from the registers, 37 bits
  typedef struct packed {
    cpuctrl_t          cpuctrl;
    logic [31:0]       lfsr0;
  } xsecure_ctrl_t;

  // Register select on the write and read port
  typedef enum logic {
    CSR_CPUCTRL     = 1'b0,
    CSR_SECURESEED0 = 1'b1
  } csr_sel_e;

endpackage

// ==== verif/dummy_instr_checker.sv ====
////////////////////////////////////////
// Counter assertions for the insert controller. Bound into the top
// level, where the register write strobes are also visible.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_instr_checker import dummy_pkg::*; (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     cpuctrl_we,
  input cpuctrl_t                 cpuctrl,
  input cpuctrl_t                 cpuctrl_n,
  input logic                     secureseed0_we,
  input logic                     dummy_insert,
  input logic [LFSRCNT_WIDTH-1:0] lfsr_cnt,
  input logic [CNT_WIDTH-1:0]     cnt_q
);

  // Set by a write that changes cpuctrl or by any seed write, cleared by
  // the next insert
  logic sw_update_q;

  // Failed assertions so far, read by the testbench at the end
  int assert_fails = 0;

  logic [CNT_WIDTH-1:0] cnt_cmp;
  logic [CNT_WIDTH-1:0] cnt_target;

  assign cnt_cmp    = CNT_WIDTH'(lfsr_cnt);
  assign cnt_target = cnt_cmp + CNT_WIDTH'(1);

  // A write in the same cycle as an insert keeps the flag set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_update_q <= 1'b0;
    end else if ((cpuctrl_we && (cpuctrl_n != cpuctrl)) || secureseed0_we) begin
      sw_update_q <= 1'b1;
    end else if (dummy_insert) begin
      sw_update_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // Without a software update the pulse lands exactly at lfsr_cnt+1
  insert_at_target: assert property (@(posedge clk) disable iff (!rst_n)
    dummy_insert |-> (sw_update_q || cnt_q == cnt_target))
    else begin
      assert_fails++;
      $error("insert with count %0d, target %0d", cnt_q, cnt_target);
    end

  // Once past the compare value the counter never moves upward
  cnt_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q > cnt_cmp) |=> (cnt_q <= $past(cnt_q)))
    else begin
      assert_fails++;
      $error("counter grew past the compare value to %0d", cnt_q);
    end

endmodule

// The counter lives inside the controller instance
bind dummy_instr_top dummy_instr_checker checker_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .cpuctrl_we     (cpuctrl_we),
  .cpuctrl        (xsecure_ctrl.cpuctrl),
  .cpuctrl_n      (cpuctrl_n),
  .secureseed0_we (secureseed0_we),
  .dummy_insert   (dummy_insert),
  .lfsr_cnt       (lfsr_cnt),
  .cnt_q          (dummy_insert_ctrl_i.cnt_q)
);

// ==== verif/dummy_instr_tb.sv ====
////////////////////////////////////////
// Testbench for the insertion unit. Applies a table of register writes,
// reads and issue bursts, and checks every cycle against a model.
////////////////////////////////////////

`timescale 1ns/100ps

module dummy_instr_tb import dummy_pkg::*;;

  typedef enum logic [1:0] {ACT_CTRL, ACT_SEED, ACT_READ, ACT_ISSUE} act_e;

  // Table row; for issue rows exp is a lower bound on the longest interval,
  // and an exp of 0 means the row must see no pulse at all
  typedef struct packed {
    act_e        act;
    logic [31:0] data;
    logic [31:0] exp;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        csr_we;
  csr_sel_e    csr_sel;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic        instr_issue;
  logic        dummy_insert;

  row_t  rows_q[$];
  string names_q[$];
  string cur_name;

  // Model state as it stands after the latest clock edge
  logic        m_en;
  logic [3:0]  m_freq;
  logic [31:0] m_lfsr;
  int          m_cnt;

  int     issues_since;
  int     max_int;
  int     row_pulses;
  int     errors;
  int     failed;
  int     limit;
  int     cycles = 0;
  logic   dirty;
  integer seed;

  dummy_instr_top dummy_instr_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] r;
    r = s >> 1;
    if (s[0]) r = r ^ LFSR_TAPS;
    return r;
  endfunction

  // Low six state bits under a mask of freq+2 ones, freq clamped to 4
  function automatic int cmp_value(input logic [31:0] s, input logic [3:0] f);
    int fc;
    fc = (f > 4'd4) ? 4 : int'(f);
    return int'(s[5:0]) & ((1 << (fc + 2)) - 1);
  endfunction

  task automatic add_row(input string name, input act_e act, input logic [31:0] data,
                         input logic [31:0] exp);
    names_q.push_back(name);
    rows_q.push_back('{act: act, data: data, exp: exp});
  endtask

  // Drives one cycle, checks the insert pulse and advances the model
  task automatic step_cycle(input logic we, input csr_sel_e sel, input logic [31:0] wdata,
                            input logic issue);
    int   cmp;
    logic ins;
    @(posedge clk);
    csr_we      <= we;
    csr_sel     <= sel;
    csr_wdata   <= wdata;
    instr_issue <= issue;
    @(negedge clk);
    cmp = cmp_value(m_lfsr, m_freq);
    ins = m_en && (m_cnt > cmp);
    if (dummy_insert !== ins) begin
      $display("error %s: dummy_insert expected %0b actual %0b", cur_name, ins, dummy_insert);
      errors++;
    end
    // Spacing is only checked when software left the compare value alone
    if (dummy_insert) begin
      row_pulses++;
      if (!dirty && issues_since != cmp + 1) begin
        $display("error %s: interval expected %0d actual %0d", cur_name, cmp + 1, issues_since);
        errors++;
      end
      if (issues_since > max_int) max_int = issues_since;
      issues_since = 0;
      dirty = 1'b0;
    end else if (!m_en) begin
      // A disabled unit holds the count at zero, so the next interval starts clean
      issues_since = 0;
      dirty        = 1'b0;
    end else if (issue) begin
      issues_since++;
    end
    if (!m_en || ins) m_cnt = 0;
    else if (issue) m_cnt++;
    // A seed load wins over the step of a pulse in the same cycle
    if (we && sel == CSR_SECURESEED0) begin
      m_lfsr = (wdata == '0) ? LFSR_DEFAULT_SEED : wdata;
      dirty  = 1'b1;
    end else if (ins) begin
      m_lfsr = lfsr_next(m_lfsr);
    end
    if (we && sel == CSR_CPUCTRL) begin
      if (wdata[4:1] != m_freq) dirty = 1'b1;
      m_en   = wdata[0];
      m_freq = wdata[4:1];
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table and main loop
  ////////////////////////////////////////

  initial begin
    int       total;
    int       gap;
    int       start_err;
    row_t     r;
    csr_sel_e sel;
    rst_n       = 1'b0;
    csr_we      = 1'b0;
    csr_sel     = CSR_CPUCTRL;
    csr_wdata   = '0;
    instr_issue = 1'b0;
    seed        = 32'ha114;
    errors      = 0;
    failed      = 0;
    dirty       = 1'b0;
    issues_since = 0;
    m_en   = 1'b0;
    m_freq = 4'd0;
    m_lfsr = LFSR_DEFAULT_SEED;
    m_cnt  = 0;
    add_row("reset_issue",     ACT_ISSUE, 20, 0);
    add_row("reset_rd_ctrl",   ACT_READ,  0, 0);
    add_row("reset_rd_seed",   ACT_READ,  1, 0);
    add_row("seed_write",      ACT_SEED,  32'h1234_5678, 32'h1234_5678);
    add_row("enable_freq0",    ACT_CTRL,  32'hFFFF_FFE1, 32'h1);
    add_row("spacing_freq0",   ACT_ISSUE, 40, 1);
    add_row("seed_zero",       ACT_SEED,  32'h0, 32'h0);
    add_row("spacing_default", ACT_ISSUE, 30, 1);
    add_row("enable_freq4",    ACT_CTRL,  32'h9, 32'h9);
    add_row("spacing_freq4",   ACT_ISSUE, 200, 5);
    add_row("enable_freq15",   ACT_CTRL,  32'h1F, 32'h1F);
    add_row("spacing_freq15",  ACT_ISSUE, 150, 5);
    add_row("disable",         ACT_CTRL,  32'h8, 32'h8);
    add_row("disabled_issue",  ACT_ISSUE, 40, 0);
    add_row("reenable",        ACT_CTRL,  32'h9, 32'h9);
    add_row("reenable_issue",  ACT_ISSUE, 80, 1);
    add_row("reseed",          ACT_SEED,  32'hA5A5_0F0F, 32'hA5A5_0F0F);
    add_row("reseed_issue",    ACT_ISSUE, 120, 1);
    // Each issue takes at most three cycles with its gap
    total = 0;
    foreach (rows_q[i]) if (rows_q[i].act == ACT_ISSUE) total += int'(rows_q[i].data);
    limit = total * 4 + 200;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    foreach (rows_q[i]) begin
      r          = rows_q[i];
      cur_name   = names_q[i];
      start_err  = errors;
      row_pulses = 0;
      max_int    = 0;
      if (r.act == ACT_ISSUE) begin
        for (int n = 0; n < int'(r.data); n++) begin
          gap = {$random(seed)} % 3;
          repeat (gap) step_cycle(1'b0, CSR_CPUCTRL, '0, 1'b0);
          step_cycle(1'b0, CSR_CPUCTRL, '0, 1'b1);
        end
        // Lets a pulse owed to the last issue land in this row
        repeat (2) step_cycle(1'b0, CSR_CPUCTRL, '0, 1'b0);
        if (r.exp == 0) begin
          if (row_pulses != 0) begin
            $display("error %s: pulses expected 0 actual %0d", cur_name, row_pulses);
            errors++;
          end
        end else if (max_int < int'(r.exp)) begin
          $display("error %s: longest interval expected >= %0d actual %0d",
                   cur_name, r.exp, max_int);
          errors++;
        end
      end else begin
        sel = (r.act == ACT_READ) ? csr_sel_e'(r.data[0]) :
              (r.act == ACT_SEED) ? CSR_SECURESEED0 : CSR_CPUCTRL;
        if (r.act != ACT_READ) step_cycle(1'b1, sel, r.data, 1'b0);
        step_cycle(1'b0, sel, '0, 1'b0);
        if (csr_rdata !== r.exp) begin
          $display("error %s: readback expected %h actual %h", cur_name, r.exp, csr_rdata);
          errors++;
        end
      end
      if (errors == start_err) begin
        $display("%s ok, %0d pulses", cur_name, row_pulses);
      end else begin
        failed++;
        $display("%s FAILED, %0d errors", cur_name, errors - start_err);
      end
    end
    if (dummy_instr_top_i.checker_i.assert_fails != 0) begin
      $display("The bound checker saw %0d assertion failures",
               dummy_instr_top_i.checker_i.assert_fails);
      errors += dummy_instr_top_i.checker_i.assert_fails;
    end
    $display("Tests run %0d, failed %0d, errors %0d", rows_q.size(), failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
